// File: sources.f
hw/dcore_pkg.sv
hw/adc_unfold.sv
hw/snapshot_mem.sv
hw/prbs_checker.sv
hw/dcore_regs.sv
hw/digital_core.sv
tb/digital_core_sva.sv
tb/tb_digital_core.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_digital_core -f sources.f -o tb_digital_core \
    && ./obj_dir/tb_digital_core +verilator+error+limit+1000 2>&1 | tee sim.log \
    || echo "build or simulation aborted"

grep -qx "RESULT: PASS" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tb/tb_digital_core.sv
`timescale 1ns/1ps

module tb_digital_core;

    import dcore_pkg::*;

    localparam int n_ti      = 16;
    localparam int n_adc     = 7;
    localparam int mem_depth = 32;
    localparam int n_words   = mem_depth * n_ti;
    localparam int n_flips   = 6;
    // word strides for the plain dump and the offset dumps
    localparam int stride_a  = 3;
    localparam int stride_b  = 7;
    // four cycles per memory read, plus dumps, register traffic and prbs runs
    localparam int est_cycles = 4 * (n_words / stride_a + 3 * n_words / stride_b)
                                + 4 * (2 * mem_depth + 16) + 300;
    localparam int max_cycles = 3 * est_cycles;

    logic                           clk_adc;
    logic                           arst_n_i;
    logic [n_ti-1:0][n_adc-1:0]     adcout_i;
    logic [n_ti-1:0]                adcout_sign_i;
    logic                           ext_dump_start_i;
    logic                           psel_i;
    logic                           penable_i;
    logic                           pwrite_i;
    logic [apb_addr_w-1:0]          paddr_i;
    logic [apb_data_w-1:0]          pwdata_i;
    logic [apb_data_w-1:0]          prdata_o;
    logic                           pready_o;
    logic                           pslverr_o;

    int                 errors = 0;
    int                 checks = 0;
    int                 cycles = 0;
    logic [31:0]        lcg_state = 32'h2727_ff4d;
    logic [6:0]         prbs_hist = 7'h5a;
    logic               dump_req = 1'b0;
    logic               capturing = 1'b0;
    int                 cap_idx = 0;
    int                 flip_left = 0;
    int                 flip_gap = 0;
    logic [n_adc-1:0]   ref_mag [n_words];
    logic               ref_sign [n_words];
    logic [n_adc-1:0]   mag_v;
    logic               sign_v;
    logic [31:0]        rd_v;
    logic               err_v;
    int                 waits_v;
    int                 offsets [3] = '{100, -128, 27};

    digital_core #(
        .n_ti      (n_ti),
        .n_adc     (n_adc),
        .mem_depth (mem_depth)
    ) dut_i (.*);

    bind digital_core digital_core_sva #(
        .n_ti      (n_ti),
        .mem_depth (mem_depth)
    ) sva_i (
        .clk_adc   (clk_adc),
        .arst_n_i  (arst_n_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // signed value of one lane after offset and clamping
    function automatic logic [31:0] unfold_ref(input logic sign, input logic [n_adc-1:0] mag,
                                               input int off);
        int v;
        v = (sign ? int'(mag) : -int'(mag)) - off;
        if (v > (1 << n_adc) - 1)
            v = (1 << n_adc) - 1;
        else if (v < -(1 << n_adc))
            v = -(1 << n_adc);
        return 32'(v);
    endfunction

    initial begin
        clk_adc = 1'b0;
        forever #50 clk_adc = ~clk_adc;
    end

    initial begin
        while (cycles < max_cycles) begin
            @(posedge clk_adc);
            cycles++;
        end
        $display("ERROR: run stopped after %0d cycles without finishing", cycles);
        $display("RESULT: FAIL");
        $finish;
    end

    // new lanes every cycle with prbs7 signs
    always @(negedge clk_adc) begin
        for (int lane = 0; lane < n_ti; lane++) begin
            lcg_state = lcg_next(lcg_state);
            mag_v = lcg_state[30:24];
            if (mag_v == '0)
                mag_v = 1;
            sign_v = prbs_hist[prbs_tap_a-1] ^ prbs_hist[prbs_tap_b-1];
            prbs_hist = {prbs_hist[5:0], sign_v};
            // injected error leaves the generator history clean
            if (lane == 10 && flip_left > 0 && flip_gap == 0) begin
                sign_v = !sign_v;
                flip_left--;
                flip_gap = 4;
            end
            adcout_i[lane] = mag_v;
            adcout_sign_i[lane] = sign_v;
        end
        if (flip_gap > 0)
            flip_gap--;
        ext_dump_start_i = dump_req;
        if (dump_req) begin
            capturing = 1'b1;
            cap_idx = 0;
            dump_req = 1'b0;
        end
        // inputs sampled from the start edge on land in entry 0 upwards
        if (capturing) begin
            for (int lane = 0; lane < n_ti; lane++) begin
                ref_mag[cap_idx*n_ti+lane] = adcout_i[lane];
                ref_sign[cap_idx*n_ti+lane] = adcout_sign_i[lane];
            end
            cap_idx++;
            if (cap_idx == mem_depth)
                capturing = 1'b0;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %0t ns: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic apb_xfer(input logic wr, input logic [15:0] addr, input logic [31:0] wdata);
        @(negedge clk_adc);
        psel_i = 1'b1;
        penable_i = 1'b0;
        pwrite_i = wr;
        paddr_i = addr;
        pwdata_i = wdata;
        @(negedge clk_adc);
        penable_i = 1'b1;
        waits_v = 0;
        while (!pready_o) begin
            @(negedge clk_adc);
            waits_v++;
        end
        rd_v = prdata_o;
        err_v = pslverr_o;
        @(negedge clk_adc);
        psel_i = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
        apb_xfer(1'b1, addr, data);
        check_value("pslverr_o", 32'(err_v), 0);
        check_value("register wait states", 32'(waits_v), 0);
    endtask

    task automatic expect_reg(input string name, input logic [15:0] addr,
                              input logic [31:0] exp);
        apb_xfer(1'b0, addr, '0);
        check_value(name, rd_v, exp);
        check_value("pslverr_o", 32'(err_v), 0);
        check_value("register wait states", 32'(waits_v), 0);
    endtask

    task automatic check_word(input int idx, input int off);
        apb_xfer(1'b0, mem_base + 16'(4 * idx), '0);
        check_value($sformatf("mem word %0d", idx), rd_v,
                    unfold_ref(ref_sign[idx], ref_mag[idx], off));
        check_value("memory wait states", 32'(waits_v), 1);
    endtask

    task automatic run_dump();
        int polls;
        polls = 0;
        @(posedge clk_adc);
        dump_req = 1'b1;
        repeat (2) @(posedge clk_adc);
        apb_xfer(1'b0, reg_status, '0);
        check_value("status", rd_v, 32'h2);
        while (!rd_v[status_done_bit] && polls < 2 * mem_depth) begin
            apb_xfer(1'b0, reg_status, '0);
            polls++;
        end
        check_value("status", rd_v, 32'h1);
    endtask

    task automatic check_prbs(input int exp_err);
        expect_reg("prbs error count", reg_prbs_err, 32'(exp_err));
        apb_xfer(1'b0, reg_prbs_total, '0);
        check_value("prbs total mod n_ti", rd_v % 32'(n_ti), 0);
        assert (rd_v != 0) else begin
            $display("ERROR: %0t ns: prbs checker counted no bits", $time);
            errors++;
        end
    endtask

    initial begin
        arst_n_i = 1'b1;
        adcout_i = '0;
        adcout_sign_i = '0;
        ext_dump_start_i = 1'b0;
        psel_i = 1'b0;
        penable_i = 1'b0;
        pwrite_i = 1'b0;
        paddr_i = '0;
        pwdata_i = '0;
        #1;
        arst_n_i = 1'b0;
        repeat (5) @(negedge clk_adc);
        arst_n_i = 1'b1;

        expect_reg("ctrl", reg_ctrl, 0);
        expect_reg("offset", reg_offset, 0);
        expect_reg("thresh", reg_thresh, 0);
        expect_reg("status", reg_status, 0);
        expect_reg("prbs total", reg_prbs_total, 0);
        expect_reg("prbs error count", reg_prbs_err, 0);

        run_dump();
        for (int idx = 0; idx < n_words; idx += stride_a)
            check_word(idx, 0);

        // large offsets push both ends into saturation
        foreach (offsets[k]) begin
            write_reg(reg_offset, 32'(offsets[k]));
            expect_reg("offset", reg_offset, 32'(offsets[k]));
            run_dump();
            for (int idx = k; idx < n_words; idx += stride_b)
                check_word(idx, offsets[k]);
        end
        write_reg(reg_offset, 0);

        write_reg(reg_thresh, 0);
        write_reg(reg_ctrl, 32'h3);
        expect_reg("ctrl", reg_ctrl, 1);
        repeat (40) @(posedge clk_adc);
        write_reg(reg_ctrl, 0);
        check_prbs(0);

        // each flipped bit is seen at n, n+6 and n+7
        write_reg(reg_ctrl, 32'h3);
        @(posedge clk_adc);
        flip_left = n_flips;
        wait (flip_left == 0);
        repeat (4) @(posedge clk_adc);
        write_reg(reg_ctrl, 0);
        check_prbs(3 * n_flips);

        apb_xfer(1'b0, 16'h0020, '0);
        check_value("pslverr_o on unmapped read", 32'(err_v), 1);
        check_value("unmapped wait states", 32'(waits_v), 0);
        apb_xfer(1'b0, mem_base + 16'(4 * n_words), '0);
        check_value("pslverr_o past window", 32'(err_v), 1);
        apb_xfer(1'b1, mem_base + 16'(4 * 5), 32'h0000_0055);
        check_value("pslverr_o on window write", 32'(err_v), 1);
        check_value("window write wait states", 32'(waits_v), 0);
        check_word(5, offsets[2]);

        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, dut_i.sva_i.fail_count);
        if (errors == 0 && dut_i.sva_i.fail_count == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: tb/digital_core_sva.sv
`timescale 1ns/1ps

module digital_core_sva #(
    parameter int n_ti      = 16,
    parameter int mem_depth = 32
) (
    input logic                             clk_adc,
    input logic                             arst_n_i,
    input logic                             psel_i,
    input logic                             penable_i,
    input logic                             pwrite_i,
    input logic [dcore_pkg::apb_addr_w-1:0] paddr_i,
    input logic [dcore_pkg::apb_data_w-1:0] prdata_o,
    input logic                             pready_o,
    input logic                             pslverr_o
);

    import dcore_pkg::*;

    int                     fail_count = 0;
    logic [apb_addr_w-1:0]  mem_off;
    logic                   mem_hit;
    logic                   mem_rd_setup;

    assign mem_off = paddr_i - mem_base;
    assign mem_hit = (paddr_i >= mem_base) && (mem_off[1:0] == 2'b00) &&
                     (int'(mem_off[apb_addr_w-1:2]) < mem_depth * n_ti);

    // setup cycle of a read inside the snapshot window
    assign mem_rd_setup = psel_i && !penable_i && !pwrite_i && mem_hit;

    ready_in_access: assert property (@(posedge clk_adc) disable iff (!arst_n_i)
        pready_o |-> (psel_i && penable_i))
    else begin
        $error("pready_o high outside an APB access phase");
        fail_count++;
    end

    slverr_with_ready: assert property (@(posedge clk_adc) disable iff (!arst_n_i)
        pslverr_o |-> pready_o)
    else begin
        $error("pslverr_o high without pready_o");
        fail_count++;
    end

    // ram needs one cycle before data is valid
    mem_read_wait: assert property (@(posedge clk_adc) disable iff (!arst_n_i)
        mem_rd_setup |=> !pready_o)
    else begin
        $error("memory window read completed without a wait state");
        fail_count++;
    end

    quiet_in_reset: assert property (@(posedge clk_adc)
        !arst_n_i |-> (prdata_o == '0 && !pready_o && !pslverr_o))
    else begin
        $error("APB outputs not idle during reset");
        fail_count++;
    end

endmodule

// File: hw/digital_core.sv
`timescale 1ns/1ps
`default_nettype none

module digital_core #(
    parameter int n_ti      = 16,
    parameter int n_adc     = 7,
    parameter int mem_depth = 32
) (
    input  logic                              clk_adc,
    input  logic                              arst_n_i,
    input  logic [n_ti-1:0][n_adc-1:0]        adcout_i,
    input  logic [n_ti-1:0]                   adcout_sign_i,
    input  logic                              ext_dump_start_i,
    input  logic                              psel_i,
    input  logic                              penable_i,
    input  logic                              pwrite_i,
    input  logic [dcore_pkg::apb_addr_w-1:0]  paddr_i,
    input  logic [dcore_pkg::apb_data_w-1:0]  pwdata_i,
    output logic [dcore_pkg::apb_data_w-1:0]  prdata_o,
    output logic                              pready_o,
    output logic                              pslverr_o
);

    import dcore_pkg::*;

    logic [n_ti-1:0][n_adc:0]               codes;
    logic signed [n_adc:0]                  offset;
    logic signed [n_adc:0]                  thresh;
    logic                                   prbs_en;
    logic                                   prbs_clear;
    logic [$clog2(mem_depth*n_ti)-1:0]      mem_raddr;
    logic [apb_data_w-1:0]                  mem_rdata;
    logic                                   dump_busy;
    logic                                   dump_done;
    logic [apb_data_w-1:0]                  prbs_total;
    logic [apb_data_w-1:0]                  prbs_err;

    // host access
    dcore_regs #(
        .n_ti      (n_ti),
        .n_adc     (n_adc),
        .mem_depth (mem_depth)
    ) regs_i (
        .clk_adc      (clk_adc),
        .arst_n_i     (arst_n_i),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .paddr_i      (paddr_i),
        .pwdata_i     (pwdata_i),
        .mem_rdata_i  (mem_rdata),
        .dump_busy_i  (dump_busy),
        .dump_done_i  (dump_done),
        .total_i      (prbs_total),
        .err_i        (prbs_err),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o),
        .offset_o     (offset),
        .thresh_o     (thresh),
        .prbs_en_o    (prbs_en),
        .prbs_clear_o (prbs_clear),
        .mem_raddr_o  (mem_raddr)
    );

    adc_unfold #(
        .n_ti  (n_ti),
        .n_adc (n_adc)
    ) unfold_i (
        .clk_adc       (clk_adc),
        .arst_n_i      (arst_n_i),
        .adcout_i      (adcout_i),
        .adcout_sign_i (adcout_sign_i),
        .offset_i      (offset),
        .codes_o       (codes)
    );

    // capture buffer
    snapshot_mem #(
        .n_ti      (n_ti),
        .n_adc     (n_adc),
        .mem_depth (mem_depth)
    ) snapshot_i (
        .clk_adc      (clk_adc),
        .arst_n_i     (arst_n_i),
        .codes_i      (codes),
        .dump_start_i (ext_dump_start_i),
        .raddr_i      (mem_raddr),
        .rdata_o      (mem_rdata),
        .dump_busy_o  (dump_busy),
        .dump_done_o  (dump_done)
    );

    prbs_checker #(
        .n_ti  (n_ti),
        .n_adc (n_adc)
    ) prbs_i (
        .clk_adc  (clk_adc),
        .arst_n_i (arst_n_i),
        .codes_i  (codes),
        .thresh_i (thresh),
        .en_i     (prbs_en),
        .clear_i  (prbs_clear),
        .total_o  (prbs_total),
        .err_o    (prbs_err)
    );

endmodule

`default_nettype wire

// File: hw/dcore_regs.sv
`timescale 1ns/1ps
`default_nettype none

module dcore_regs #(
    parameter int n_ti      = 16,
    parameter int n_adc     = 7,
    parameter int mem_depth = 32
) (
    input  logic                                  clk_adc,
    input  logic                                  arst_n_i,
    input  logic                                  psel_i,
    input  logic                                  penable_i,
    input  logic                                  pwrite_i,
    input  logic [dcore_pkg::apb_addr_w-1:0]      paddr_i,
    input  logic [dcore_pkg::apb_data_w-1:0]      pwdata_i,
    input  logic [dcore_pkg::apb_data_w-1:0]      mem_rdata_i,
    input  logic                                  dump_busy_i,
    input  logic                                  dump_done_i,
    input  logic [dcore_pkg::apb_data_w-1:0]      total_i,
    input  logic [dcore_pkg::apb_data_w-1:0]      err_i,
    output logic [dcore_pkg::apb_data_w-1:0]      prdata_o,
    output logic                                  pready_o,
    output logic                                  pslverr_o,
    output logic signed [n_adc:0]                 offset_o,
    output logic signed [n_adc:0]                 thresh_o,
    output logic                                  prbs_en_o,
    output logic                                  prbs_clear_o,
    output logic [$clog2(mem_depth*n_ti)-1:0]     mem_raddr_o
);

    import dcore_pkg::*;

    localparam int mem_words = mem_depth * n_ti;
    localparam int aw        = $clog2(mem_words);

    logic                       setup;
    logic                       access;
    logic                       reg_hit;
    logic                       mem_hit;
    logic [apb_addr_w-1:0]      mem_off;
    logic [apb_data_w-1:0]      reg_rdata;

    assign setup  = psel_i & ~penable_i;
    assign access = psel_i & penable_i;

    // memory window, word aligned and inside the captured range
    assign mem_off     = paddr_i - mem_base;
    assign mem_hit     = (paddr_i >= mem_base) && (mem_off[1:0] == 2'b00) &&
                         (int'(mem_off[apb_addr_w-1:2]) < mem_words);
    assign mem_raddr_o = mem_off[aw+1:2];

    always_comb begin
        reg_hit   = 1'b1;
        reg_rdata = '0;
        case (paddr_i)
            reg_ctrl:       reg_rdata[ctrl_prbs_en_bit] = prbs_en_o;
            // signed casts sign-extend
            reg_offset:     reg_rdata = apb_data_w'(offset_o);
            reg_thresh:     reg_rdata = apb_data_w'(thresh_o);
            reg_status: begin
                reg_rdata[status_done_bit] = dump_done_i;
                reg_rdata[status_busy_bit] = dump_busy_i;
            end
            reg_prbs_total: reg_rdata = total_i;
            reg_prbs_err:   reg_rdata = err_i;
            default:        reg_hit = 1'b0;
        endcase
    end

    always_ff @(posedge clk_adc or negedge arst_n_i) begin
        if (!arst_n_i) begin
            prdata_o     <= '0;
            pready_o     <= 1'b0;
            pslverr_o    <= 1'b0;
            offset_o     <= '0;
            thresh_o     <= '0;
            prbs_en_o    <= 1'b0;
            prbs_clear_o <= 1'b0;
        end else begin
            pready_o     <= 1'b0;
            pslverr_o    <= 1'b0;
            prbs_clear_o <= 1'b0;
            if (setup) begin
                // everything but a memory read completes in the first access cycle
                if (!(mem_hit && !pwrite_i)) begin
                    pready_o  <= 1'b1;
                    pslverr_o <= !reg_hit;
                    prdata_o  <= (reg_hit && !pwrite_i) ? reg_rdata : '0;
                end
            end else if (access && !pready_o) begin
                // memory read, ram data valid one cycle after the address
                pready_o <= 1'b1;
                prdata_o <= mem_rdata_i;
            end
            if (access && pready_o && pwrite_i && reg_hit) begin
                case (paddr_i)
                    reg_ctrl: begin
                        prbs_en_o    <= pwdata_i[ctrl_prbs_en_bit];
                        prbs_clear_o <= pwdata_i[ctrl_prbs_clear_bit];
                    end
                    reg_offset: offset_o <= pwdata_i[n_adc:0];
                    reg_thresh: thresh_o <= pwdata_i[n_adc:0];
                    // status and counters are read only
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/prbs_checker.sv
`timescale 1ns/1ps
`default_nettype none

module prbs_checker #(
    parameter int n_ti  = 16,
    parameter int n_adc = 7
) (
    input  logic                              clk_adc,
    input  logic                              arst_n_i,
    input  logic [n_ti-1:0][n_adc:0]          codes_i,
    input  logic signed [n_adc:0]             thresh_i,
    input  logic                              en_i,
    input  logic                              clear_i,
    output logic [dcore_pkg::apb_data_w-1:0]  total_o,
    output logic [dcore_pkg::apb_data_w-1:0]  err_o
);

    import dcore_pkg::*;

    localparam int hl    = prbs_tap_b;
    localparam int cnt_w = $clog2(n_ti + 1);

    logic [n_ti-1:0]        slice_d;
    logic [n_ti-1:0]        bits_q;
    logic [hl-1:0]          hist_q;
    logic [n_ti+hl-1:0]     stream;
    logic [n_ti-1:0]        mism;
    logic [cnt_w-1:0]       mism_cnt;

    // serial order, history below, lane 0 right after the newest history bit
    assign stream = {bits_q, hist_q};

    for (genvar j = 0; j < n_ti; j++) begin : g_bit
        assign slice_d[j] = $signed(codes_i[j]) > thresh_i;
        assign mism[j]    = stream[j+hl] ^ stream[j+hl-prbs_tap_a]
                                         ^ stream[j+hl-prbs_tap_b];
    end

    always_comb begin
        mism_cnt = '0;
        for (int j = 0; j < n_ti; j++) begin
            mism_cnt = mism_cnt + cnt_w'(mism[j]);
        end
    end

    // sliced bits, one cycle behind the codes
    always_ff @(posedge clk_adc) begin
        bits_q <= slice_d;
    end

    always_ff @(posedge clk_adc or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hist_q  <= '0;
            total_o <= '0;
            err_o   <= '0;
        end else begin
            // history runs even while disabled so the checker stays locked
            hist_q <= stream[n_ti+hl-1:n_ti];
            if (clear_i) begin
                total_o <= '0;
                err_o   <= '0;
            end else if (en_i) begin
                total_o <= total_o + apb_data_w'(n_ti);
                err_o   <= err_o + apb_data_w'(mism_cnt);
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/snapshot_mem.sv
`timescale 1ns/1ps
`default_nettype none

module snapshot_mem #(
    parameter int n_ti      = 16,
    parameter int n_adc     = 7,
    parameter int mem_depth = 32
) (
    input  logic                                  clk_adc,
    input  logic                                  arst_n_i,
    input  logic [n_ti-1:0][n_adc:0]              codes_i,
    input  logic                                  dump_start_i,
    input  logic [$clog2(mem_depth*n_ti)-1:0]     raddr_i,
    output logic [dcore_pkg::apb_data_w-1:0]      rdata_o,
    output logic                                  dump_busy_o,
    output logic                                  dump_done_o
);

    import dcore_pkg::*;

    localparam int cw = n_adc + 1;
    localparam int aw = $clog2(mem_depth * n_ti);
    localparam int pw = $clog2(mem_depth);
    localparam int lw = $clog2(n_ti);

    // one row holds all lanes of one cycle
    logic [n_ti-1:0][cw-1:0]    mem_q [mem_depth];

    logic                       start_q;
    logic                       start_rise;
    logic [pw-1:0]              wr_ptr_q;
    logic [pw-1:0]              rd_row;
    logic [lw-1:0]              rd_lane;
    logic [cw-1:0]              rd_q;

    assign start_rise = dump_start_i & ~start_q;

    always_ff @(posedge clk_adc or negedge arst_n_i) begin
        if (!arst_n_i) begin
            start_q     <= 1'b0;
            dump_busy_o <= 1'b0;
            dump_done_o <= 1'b0;
            wr_ptr_q    <= '0;
        end else begin
            start_q <= dump_start_i;
            // a start edge during capture is dropped
            if (start_rise && !dump_busy_o) begin
                dump_busy_o <= 1'b1;
                dump_done_o <= 1'b0;
                wr_ptr_q    <= '0;
            end else if (dump_busy_o) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
                if (wr_ptr_q == pw'(mem_depth - 1)) begin
                    dump_busy_o <= 1'b0;
                    dump_done_o <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_adc) begin
        if (dump_busy_o) begin
            mem_q[wr_ptr_q] <= codes_i;
        end
    end

    // word index = entry * n_ti + lane
    assign rd_row  = pw'(raddr_i / aw'(n_ti));
    assign rd_lane = lw'(raddr_i % aw'(n_ti));

    always_ff @(posedge clk_adc) begin
        rd_q <= mem_q[rd_row][rd_lane];
    end

    assign rdata_o = {{(apb_data_w - cw){rd_q[cw-1]}}, rd_q};

endmodule

`default_nettype wire

// File: hw/adc_unfold.sv
`timescale 1ns/1ps
`default_nettype none

module adc_unfold #(
    parameter int n_ti  = 16,
    parameter int n_adc = 7
) (
    input  logic                          clk_adc,
    input  logic                          arst_n_i,
    input  logic [n_ti-1:0][n_adc-1:0]    adcout_i,
    input  logic [n_ti-1:0]               adcout_sign_i,
    input  logic signed [n_adc:0]         offset_i,
    output logic [n_ti-1:0][n_adc:0]      codes_o
);

    localparam int cw = n_adc + 1;

    // limits of the output code, one guard bit wider
    localparam logic signed [cw:0] code_max = {2'b00, {n_adc{1'b1}}};
    localparam logic signed [cw:0] code_min = {2'b11, {n_adc{1'b0}}};

    logic signed [cw:0]         offset_ext;
    logic [n_ti-1:0][cw-1:0]    sat_d;

    assign offset_ext = {offset_i[cw-1], offset_i};

    for (genvar i = 0; i < n_ti; i++) begin : g_lane
        logic signed [cw:0] mag_ext;
        logic signed [cw:0] diff;

        // sign bit 1 means positive
        assign mag_ext = {2'b00, adcout_i[i]};
        assign diff    = (adcout_sign_i[i] ? mag_ext : -mag_ext) - offset_ext;

        // clamp to the signed code range
        assign sat_d[i] = (diff > code_max) ? code_max[cw-1:0] :
                          (diff < code_min) ? code_min[cw-1:0] :
                          diff[cw-1:0];
    end

    always_ff @(posedge clk_adc or negedge arst_n_i) begin
        if (!arst_n_i) begin
            codes_o <= '0;
        end else begin
            codes_o <= sat_d;
        end
    end

endmodule

`default_nettype wire

// File: hw/dcore_pkg.sv
package dcore_pkg;

    // apb bus widths
    localparam int apb_addr_w = 16;
    localparam int apb_data_w = 32;

    // register map, byte addresses
    localparam logic [apb_addr_w-1:0] reg_ctrl       = 16'h0000;
    localparam logic [apb_addr_w-1:0] reg_offset     = 16'h0004;
    localparam logic [apb_addr_w-1:0] reg_thresh     = 16'h0008;
    localparam logic [apb_addr_w-1:0] reg_status     = 16'h000C;
    localparam logic [apb_addr_w-1:0] reg_prbs_total = 16'h0010;
    localparam logic [apb_addr_w-1:0] reg_prbs_err   = 16'h0014;

    // snapshot window, word k at mem_base + 4k
    localparam logic [apb_addr_w-1:0] mem_base       = 16'h1000;

    // field positions
    localparam int ctrl_prbs_en_bit    = 0;
    localparam int ctrl_prbs_clear_bit = 1;
    localparam int status_done_bit     = 0;
    localparam int status_busy_bit     = 1;

    // prbs7 recurrence b[n] = b[n-6] ^ b[n-7]
    localparam int prbs_tap_a = 6;
    localparam int prbs_tap_b = 7;

endpackage
